/* tb.f */
design/captureTypes.sv
design/LaneBuffer.sv
design/WidthConverter.sv
design/CaptureConfig.sv
design/DataStorage.sv
design/CaptureTop.sv
bench/captureTop_sva.sv
bench/tbCaptureTop.sv

/* runSim.sh */
#!/bin/sh
# build and run the capture buffer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tbCaptureTop -o simCapture
simOutput=$(./obj_dir/simCapture)
echo "$simOutput"
if echo "$simOutput" | grep -qx "No errors"; then
  exit 0
fi
exit 1

/* bench/tbCaptureTop.sv */
`timescale 1ns/100ps
`default_nettype none

module tbCaptureTop;

  import captureTypes::*;

  localparam int laneDepth = 16;
  // six bursts of at most 68 bytes, about 150 cycles each with read gaps
  localparam int maxCycles = 4000;

  logic                   ReadClock;
  logic                   reset;
  logic                   RegWrite;
  regAddrT                RegAddr;
  logic [sampleWidth-1:0] RegWriteData;
  logic                   WriteStrobe;
  logic [sampleWidth-1:0] DataIn;
  logic                   ReadEnable;
  logic [byteWidth-1:0]   DataOut;
  logic                   DataValid;
  logic                   DataReadyToSend;
  storageStateT           State;

  logic [byteWidth-1:0]   expQueue[$];     // bytes the reader should see next
  logic [sampleWidth-1:0] expSync;
  storageStateT           prevState;
  string                  testName;
  int                     errorCount = 0;
  int                     checksDone = 0;
  int                     storedCount = 0; // samples taken by the model
  int                     byteCount = 0;   // bytes seen on DataOut
  int                     cycleCount = 0;

  CaptureTop #(
    .LaneDepth      (laneDepth),
    .ConverterDepth (4)
  ) dut0 (
    .ReadClock       (ReadClock),
    .reset           (reset),
    .RegWrite        (RegWrite),
    .RegAddr         (RegAddr),
    .RegWriteData    (RegWriteData),
    .WriteStrobe     (WriteStrobe),
    .DataIn          (DataIn),
    .ReadEnable      (ReadEnable),
    .DataOut         (DataOut),
    .DataValid       (DataValid),
    .DataReadyToSend (DataReadyToSend),
    .State           (State)
  );

  initial begin
    ReadClock = 1'b0;
    forever #50 ReadClock = ~ReadClock;  // 100 ns period
  end

  always @(posedge ReadClock) DataIn <= $urandom();  // new sample every edge

  always @(posedge ReadClock) begin
    cycleCount++;
    if (cycleCount >= maxCycles) begin
      $display("Timeout: test did not finish within %0d cycles", maxCycles);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic checkByte(input string name, input logic [byteWidth-1:0] expected,
                           input logic [byteWidth-1:0] actual);
    checksDone++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR %s: byte expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  task automatic checkState(input string name, input storageStateT expected,
                            input storageStateT actual);
    checksDone++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR %s: state expected %s, actual %s", name, expected.name(), actual.name());
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    checksDone++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR %s: flag expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic checkNumber(input string name, input int expected, input int actual);
    checksDone++;
    if (actual != expected) begin
      errorCount++;
      $display("ERROR %s: count expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model run at every falling edge
  task automatic pushWord(input logic [sampleWidth-1:0] word);
    for (int i = laneCount - 1; i >= 0; i--)
      expQueue.push_back(word[i * byteWidth +: byteWidth]);  // MSB first
  endtask

  task automatic modelStep;
    if (State == stStoring) begin
      if (prevState != stStoring) begin
        pushWord(expSync);  // sync leads the burst
        checkFlag(testName, 1'b1, DataReadyToSend);  // sync word already in the converter
      end
      pushWord(DataIn);     // taken at the coming edge
      storedCount++;
    end
    if (DataValid) begin
      byteCount++;
      if (expQueue.size() == 0) begin
        errorCount++;
        $display("%s: DUT sent byte %02h when no byte was expected", testName, DataOut);
      end else
        checkByte(testName, expQueue.pop_front(), DataOut);
    end
    prevState = State;
  endtask

  task automatic writeReg(input regAddrT addr, input logic [sampleWidth-1:0] data);
    @(posedge ReadClock);
    RegWrite     <= 1'b1;
    RegAddr      <= addr;
    RegWriteData <= data;
    @(posedge ReadClock);
    RegWrite     <= 1'b0;
  endtask

  task automatic resetTest;
    repeat (2) @(posedge ReadClock);
    reset <= 1'b0;
    @(negedge ReadClock);
    checkState(testName, stReset, State);
    checkFlag(testName, 1'b0, DataValid);
    checkFlag(testName, 1'b0, DataReadyToSend);
    @(negedge ReadClock);
    checkState(testName, stReadyToStore, State);
    checkFlag(testName, 1'b0, DataValid);
    checkFlag(testName, 1'b0, DataReadyToSend);
  endtask

  // one burst from strobe to drained; reads held off until stSending if asked
  task automatic runBurst(input int samples, input bit holdOff, input bit gaps,
                          input bit toggle);
    int storedStart;
    int byteStart;
    int sendCycles;
    bit started;
    bit inSend;
    storedStart = storedCount;
    byteStart   = byteCount;
    sendCycles  = 0;
    started     = 1'b0;
    prevState   = stReadyToStore;
    @(posedge ReadClock);
    WriteStrobe <= 1'b1;  // edge seen at the next clock
    ReadEnable  <= !holdOff;
    forever begin
      @(negedge ReadClock);
      modelStep();
      if (State != stReadyToStore)
        started = 1'b1;
      else if (started)
        break;
      inSend = (State == stSending);
      if (inSend) sendCycles++;
      @(posedge ReadClock);
      if (toggle && started && (!inSend || sendCycles < 4))
        WriteStrobe <= ~WriteStrobe;  // edges the FSM must ignore
      else if (started)
        WriteStrobe <= 1'b0;
      if (holdOff)
        ReadEnable <= inSend && (!toggle || sendCycles >= 4) &&
                      (!gaps || $urandom % 2 == 0);
    end
    repeat (3) begin
      @(negedge ReadClock);
      modelStep();
      checkState(testName, stReadyToStore, State);  // no second burst
    end
    checkNumber(testName, samples, storedCount - storedStart);
    checkNumber(testName, laneCount + laneCount * samples, byteCount - byteStart);
    checkNumber(testName, 0, expQueue.size());
    checkFlag(testName, 1'b0, DataReadyToSend);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  initial begin
    void'($urandom(32'h4fc5));
    reset        = 1'b1;
    RegWrite     = 1'b0;
    RegAddr      = addrSyncWord;
    RegWriteData = '0;
    WriteStrobe  = 1'b0;
    DataIn       = '0;
    ReadEnable   = 1'b0;
    expSync      = 32'hFF80_7F00;  // value after reset
    testName = "reset";
    resetTest();
    testName = "default burst";
    writeReg(addrSampleCount, 32'd5);
    runBurst(5, 1'b0, 1'b0, 1'b0);
    testName = "new sync word";
    expSync = 32'hA5C3_0F96;
    writeReg(addrSyncWord, expSync);
    writeReg(addrSampleCount, 32'd3);
    runBurst(3, 1'b0, 1'b0, 1'b0);
    testName = "count of zero";
    writeReg(addrSampleCount, 32'd0);
    runBurst(1, 1'b0, 1'b0, 1'b0);   // stored as one
    testName = "count above depth";
    writeReg(addrSampleCount, 32'd100);
    runBurst(laneDepth, 1'b0, 1'b0, 1'b0);
    testName = "back-pressure";
    runBurst(laneDepth, 1'b1, 1'b1, 1'b0);
    testName = "ignored strobes";
    runBurst(laneDepth, 1'b1, 1'b0, 1'b1);
    $display("checks: %0d, errors: %0d", checksDone, errorCount);
    if (errorCount == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/captureTop_sva.sv */
`timescale 1ns/100ps
`default_nettype none

module storageAssertions (
  input logic                                ReadClock,
  input logic                                reset,
  input captureTypes::storageStateT          state,
  input logic                                laneWrEn,
  input logic [captureTypes::laneCount-1:0]  laneFull,
  input logic                                ReadEnable,
  input logic                                convEmpty,
  input logic                                DataValid
);

  import captureTypes::*;

  resetOneCycle: assert property (@(posedge ReadClock) disable iff (reset)
    state == stReset |=> state == stReadyToStore)
    else $error("stReset lasted more than one cycle");

  noWriteWhenFull: assert property (@(posedge ReadClock) disable iff (reset)
    laneWrEn |-> !(|laneFull))
    else $error("lane written while full");

  validAfterRead: assert property (@(posedge ReadClock) disable iff (reset)
    DataValid |-> $past(ReadEnable && !convEmpty))
    else $error("DataValid without an accepted read");

  // storing always passes through stSending
  noSkipSending: assert property (@(posedge ReadClock) disable iff (reset)
    state == stStoring |=> state != stReadyToStore)
    else $error("stStoring went straight to stReadyToStore");

endmodule

bind DataStorage storageAssertions sva0 (
  .ReadClock  (ReadClock),
  .reset      (reset),
  .state      (state),
  .laneWrEn   (laneWrEn),
  .laneFull   (laneFull),
  .ReadEnable (ReadEnable),
  .convEmpty  (convEmpty),
  .DataValid  (DataValid)
);

`default_nettype wire

/* design/CaptureTop.sv */
`timescale 1ns/100ps
`default_nettype none

module CaptureTop #(
  parameter int LaneDepth      = 16,  // samples per lane
  parameter int ConverterDepth = 4    // words in the 32-to-8 stage
) (
  input  logic                                ReadClock,
  input  logic                                reset,
  // register port
  input  logic                                RegWrite,
  input  captureTypes::regAddrT                RegAddr,
  input  logic [captureTypes::sampleWidth-1:0] RegWriteData,
  // capture side
  input  logic                                WriteStrobe,
  input  logic [captureTypes::sampleWidth-1:0] DataIn,
  // reader side
  input  logic                                ReadEnable,
  output logic [captureTypes::byteWidth-1:0]   DataOut,
  output logic                                DataValid,
  output logic                                DataReadyToSend,
  output captureTypes::storageStateT           State
);

  import captureTypes::*;

  logic [sampleWidth-1:0]             syncWord;     // config to storage
  logic [$clog2(LaneDepth + 1)-1:0]   sampleCount;

  CaptureConfig #(
    .LaneDepth (LaneDepth)
  ) config0 (
    .ReadClock    (ReadClock),
    .reset        (reset),
    .RegWrite     (RegWrite),
    .RegAddr      (RegAddr),
    .RegWriteData (RegWriteData),
    .SyncWord     (syncWord),
    .SampleCount  (sampleCount)
  );

  DataStorage #(
    .LaneDepth      (LaneDepth),
    .ConverterDepth (ConverterDepth)
  ) storage0 (
    .ReadClock       (ReadClock),
    .reset           (reset),
    .WriteStrobe     (WriteStrobe),
    .DataIn          (DataIn),
    .SyncWord        (syncWord),
    .SampleCount     (sampleCount),
    .ReadEnable      (ReadEnable),
    .DataOut         (DataOut),
    .DataValid       (DataValid),
    .DataReadyToSend (DataReadyToSend),
    .State           (State)
  );

endmodule

`default_nettype wire

/* design/DataStorage.sv */
`timescale 1ns/100ps
`default_nettype none

module DataStorage #(
  parameter int LaneDepth      = 16,
  parameter int ConverterDepth = 4
) (
  input  logic                                ReadClock,
  input  logic                                reset,
  input  logic                                WriteStrobe,  // level, rising edge starts a burst
  input  logic [captureTypes::sampleWidth-1:0] DataIn,
  input  logic [captureTypes::sampleWidth-1:0] SyncWord,
  input  logic [$clog2(LaneDepth + 1)-1:0]     SampleCount,
  input  logic                                ReadEnable,
  output logic [captureTypes::byteWidth-1:0]   DataOut,
  output logic                                DataValid,
  output logic                                DataReadyToSend,
  output captureTypes::storageStateT           State
);

  import captureTypes::*;

  localparam int CountWidth = $clog2(LaneDepth + 1);

  storageStateT          state;
  storageStateT          nextState;
  logic                  strobeDelayed;   // WriteStrobe one cycle back
  logic                  strobeRise;
  logic                  syncWrite;       // sync word into the converter
  logic [CountWidth-1:0] sampleIdx;       // samples stored so far
  logic                  lastSample;
  logic                  drained;

  // lane side
  logic                  laneClear;
  logic                  laneWrEn;
  logic                  laneRdEn;
  logic                  lanesValid;
  logic [laneCount-1:0]  laneFull;
  logic [laneCount-1:0]  laneEmpty;
  logic [laneCount-1:0]  laneValid;
  logic [sampleWidth-1:0] laneWord;       // lane outputs put back together

  // converter side
  logic                  convWrEn;
  logic [sampleWidth-1:0] convDin;
  logic                  convEmpty;
  logic                  convAlmostFull;

  assign State = state;

  ////////////////////////////////////////////////////////////////////////////
  // strobe edge, counter, state machine
  assign strobeRise = WriteStrobe & ~strobeDelayed;
  assign syncWrite  = (state == stReadyToStore) & strobeRise;  // edges elsewhere ignored
  assign lastSample = (sampleIdx == SampleCount - 1'b1);
  assign drained    = (&laneEmpty) & convEmpty & ~lanesValid;  // nothing in flight

  always_comb begin
    nextState = state;
    case (state)
      stReset:        nextState = stReadyToStore;
      stReadyToStore: if (syncWrite)  nextState = stStoring;
      stStoring:      if (lastSample) nextState = stSending;  // after SampleCount edges
      stSending:      if (drained)    nextState = stReadyToStore;
      default:        nextState = stReset;
    endcase
  end

  always_ff @(posedge ReadClock) begin
    if (reset) begin
      state         <= stReset;
      strobeDelayed <= 1'b0;
      sampleIdx     <= '0;
    end else begin
      state         <= nextState;
      strobeDelayed <= WriteStrobe;
      if (syncWrite)
        sampleIdx <= '0;               // fresh burst
      else if (laneWrEn)
        sampleIdx <= sampleIdx + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // four lane buffers
  assign laneClear  = (state == stReset);
  assign laneWrEn   = (state == stStoring);                // one sample per edge
  assign laneRdEn   = ~(|laneEmpty) & ~convAlmostFull;      // all lanes step together
  assign lanesValid = &laneValid;

  for (genvar i = 0; i < laneCount; i++) begin : genLane
    // lane 0 takes the top byte
    LaneBuffer #(
      .Depth (LaneDepth)
    ) laneBuf (
      .ReadClock (ReadClock),
      .reset     (reset),
      .clear     (laneClear),
      .wrEn      (laneWrEn),
      .din       (DataIn[sampleWidth - 1 - i * byteWidth -: byteWidth]),
      .rdEn      (laneRdEn),
      .dout      (laneWord[sampleWidth - 1 - i * byteWidth -: byteWidth]),
      .full      (laneFull[i]),
      .empty     (laneEmpty[i]),
      .valid     (laneValid[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // width converter, sync word or lane word at its write port
  assign convWrEn = syncWrite | lanesValid;  // never both, lanes empty when ready
  assign convDin  = syncWrite ? SyncWord : laneWord;

  WidthConverter #(
    .Depth (ConverterDepth)
  ) converter (
    .ReadClock  (ReadClock),
    .reset      (reset),
    .clear      (laneClear),
    .wrEn       (convWrEn),
    .din        (convDin),
    .rdEn       (ReadEnable),
    .dout       (DataOut),
    .valid      (DataValid),
    .empty      (convEmpty),
    .almostFull (convAlmostFull)     // leaves room for one read in flight
  );

  assign DataReadyToSend = ~convEmpty;

endmodule

`default_nettype wire

/* design/CaptureConfig.sv */
`timescale 1ns/100ps
`default_nettype none

module CaptureConfig #(
  parameter int LaneDepth = 16
) (
  input  logic                                ReadClock,
  input  logic                                reset,
  input  logic                                RegWrite,      // one-cycle write pulse
  input  captureTypes::regAddrT                RegAddr,
  input  logic [captureTypes::sampleWidth-1:0] RegWriteData,
  output logic [captureTypes::sampleWidth-1:0] SyncWord,
  output logic [$clog2(LaneDepth + 1)-1:0]     SampleCount
);

  import captureTypes::*;

  localparam int CountWidth = $clog2(LaneDepth + 1);

  logic [CountWidth-1:0] clampedCount;

  // count forced into 1..LaneDepth, the lanes never overflow
  always_comb begin
    if (RegWriteData == '0)
      clampedCount = CountWidth'(1);  // zero means one sample
    else if (RegWriteData > sampleWidth'(LaneDepth))
      clampedCount = CountWidth'(LaneDepth);
    else
      clampedCount = RegWriteData[CountWidth-1:0];
  end

  // register file, new value seen from the next cycle
  always_ff @(posedge ReadClock) begin
    if (reset) begin
      SyncWord    <= defaultSyncWord;
      SampleCount <= CountWidth'(LaneDepth);  // full lane by default
    end else if (RegWrite) begin
      case (RegAddr)
        addrSyncWord:    SyncWord    <= RegWriteData;
        addrSampleCount: SampleCount <= clampedCount;
        default:         SyncWord    <= SyncWord;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/WidthConverter.sv */
`timescale 1ns/100ps
`default_nettype none

module WidthConverter #(
  parameter int Depth = 4
) (
  input  logic                                ReadClock,
  input  logic                                reset,
  input  logic                                clear,
  input  logic                                wrEn,
  input  logic [captureTypes::sampleWidth-1:0] din,
  input  logic                                rdEn,
  output logic [captureTypes::byteWidth-1:0]   dout,
  output logic                                valid,
  output logic                                empty,
  output logic                                almostFull
);

  import captureTypes::*;

  localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);
  localparam int IdxWidth   = $clog2(laneCount);

  // each word viewed as laneCount bytes, index laneCount-1 is the MSB
  logic [laneCount-1:0][byteWidth-1:0] mem [Depth];

  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;    // words held
  logic [IdxWidth-1:0]   byteIdx;  // bytes already sent from the head word
  logic                  full;
  logic                  wrAccept;
  logic                  rdAccept;
  logic                  wordDone; // last byte of the head word going out

  assign full       = (count == CountWidth'(Depth));
  assign empty      = (count == '0);
  assign almostFull = (count >= CountWidth'(Depth - 1));  // under two free words
  assign wrAccept   = wrEn & ~full;
  assign rdAccept   = rdEn & ~empty;
  assign wordDone   = rdAccept & (byteIdx == '1);

  ////////////////////////////////////////////////////////////////////////////
  // control
  always_ff @(posedge ReadClock) begin
    if (reset || clear) begin
      wrPtr   <= '0;
      rdPtr   <= '0;
      count   <= '0;
      byteIdx <= '0;
      valid   <= 1'b0;
    end else begin
      if (wrAccept)
        wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
      if (rdAccept)
        byteIdx <= byteIdx + 1'b1;  // rolls to zero after the fourth byte
      if (wordDone)
        rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;  // release word
      case ({wrAccept, wordDone})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      valid <= rdAccept;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word storage and byte select
  always_ff @(posedge ReadClock) begin
    if (wrAccept)
      mem[wrPtr] <= din;
    if (rdAccept)
      dout <= mem[rdPtr][~byteIdx];  // 3,2,1,0 so MSB goes first
  end

endmodule

`default_nettype wire

/* design/LaneBuffer.sv */
`timescale 1ns/100ps
`default_nettype none

module LaneBuffer #(
  parameter int Depth = 16
) (
  input  logic                              ReadClock,
  input  logic                              reset,
  input  logic                              clear,  // sync flush, same effect as reset
  input  logic                              wrEn,
  input  logic [captureTypes::byteWidth-1:0] din,
  input  logic                              rdEn,
  output logic [captureTypes::byteWidth-1:0] dout,
  output logic                              full,
  output logic                              empty,
  output logic                              valid
);

  import captureTypes::*;

  localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);

  logic [byteWidth-1:0]  mem [Depth];
  logic [PtrWidth-1:0]   wrPtr;
  logic [PtrWidth-1:0]   rdPtr;
  logic [CountWidth-1:0] count;  // occupancy
  logic                  wrAccept;
  logic                  rdAccept;

  assign full     = (count == CountWidth'(Depth));
  assign empty    = (count == '0);
  assign wrAccept = wrEn & ~full;   // writes into a full lane are dropped
  assign rdAccept = rdEn & ~empty;

  // pointers, occupancy, read valid
  always_ff @(posedge ReadClock) begin
    if (reset || clear) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      if (wrAccept)
        wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;  // wrap
      if (rdAccept)
        rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
      case ({wrAccept, rdAccept})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      valid <= rdAccept;  // dout good one cycle after the read
    end
  end

  // storage array
  always_ff @(posedge ReadClock) begin
    if (wrAccept) mem[wrPtr] <= din;
    if (rdAccept) dout <= mem[rdPtr];  // never the slot being written, lane not empty
  end

endmodule

`default_nettype wire

/* design/captureTypes.sv */
`default_nettype none

package captureTypes;

  // stream geometry
  localparam int sampleWidth = 32;  // one DataIn word, also the sync word
  localparam int byteWidth   = 8;   // one lane, one DataOut byte
  localparam int laneCount   = 4;   // I, delayed I, Q, delayed Q

  // marker sent ahead of every burst
  localparam logic [sampleWidth-1:0] defaultSyncWord = 32'hFF80_7F00;

  ////////////////////////////////////////////////////////////////////////////
  // storage controller states, visible on State
  typedef enum logic [1:0] {
    stReset        = 2'd0,  // lanes and converter held clear
    stReadyToStore = 2'd1,  // waiting for a strobe edge
    stStoring      = 2'd2,  // lanes take DataIn every edge
    stSending      = 2'd3   // draining what is left
  } storageStateT;

  ////////////////////////////////////////////////////////////////////////////
  // register map of the config block
  typedef enum logic {
    addrSyncWord    = 1'b0,
    addrSampleCount = 1'b1
  } regAddrT;

endpackage

`default_nettype wire
